// File: build.f
+incdir+test
source/stream_demux_pkg.sv
source/stream_slice.sv
source/stream_demux_stage.sv
source/stream_demux.sv
test/tb_clock.sv
test/stream_demux_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f build.f --top-module stream_demux_tb -o stream_demux_sim

sim_output="$(./obj_dir/stream_demux_sim 2>&1 || true)"
echo "$sim_output"

if grep -q "^Verification passed$" <<< "$sim_output"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

// File: source/stream_demux.sv
`default_nettype none

module stream_demux (
    input  logic                                                       aclk,
    input  logic                                                       areset_n,
    input  logic                                                       rx_valid,
    output logic                                                       rx_ready,
    input  stream_demux_pkg::stream_beat_t                               rx_beat,
    output logic [stream_demux_pkg::TX_PORTS-1:0]                      tx_valid,
    input  logic [stream_demux_pkg::TX_PORTS-1:0]                      tx_ready,
    output stream_demux_pkg::stream_beat_t [stream_demux_pkg::TX_PORTS-1:0] tx_beat
);

    // link s feeds stage s; the last link is what no stage claimed.
    logic [stream_demux_pkg::STAGES:0] link_valid;
    logic [stream_demux_pkg::STAGES:0] link_ready;
    stream_demux_pkg::stream_beat_t [stream_demux_pkg::STAGES:0] link_beat;

    // rx enters the chain at stage 0.
    assign link_valid[0] = rx_valid;
    assign rx_ready = link_ready[0];
    assign link_beat[0] = rx_beat;

    genvar s;

    generate
        for (s = 0; s < stream_demux_pkg::STAGES; s++) begin : stage
            // group layout for this stage.
            localparam int FIRST = stream_demux_pkg::stage_first(s);
            localparam int WIDTH = stream_demux_pkg::stage_width(s);

            stream_demux_stage #(
                .FIRST(FIRST),
                .WIDTH(WIDTH)
            ) demux (
                .aclk(aclk),
                .areset_n(areset_n),
                .prev_valid(link_valid[s]),
                .prev_ready(link_ready[s]),
                .prev_beat(link_beat[s]),
                .tx_valid(tx_valid[FIRST +: WIDTH]),
                .tx_ready(tx_ready[FIRST +: WIDTH]),
                .tx_beat(tx_beat[FIRST +: WIDTH]),
                .next_valid(link_valid[s + 1]),
                .next_ready(link_ready[s + 1]),
                .next_beat(link_beat[s + 1])
            );
        end
    endgenerate

    // the tail of the chain is the extract port.
    assign tx_valid[stream_demux_pkg::EXTRACT_PORT] = link_valid[stream_demux_pkg::STAGES];
    assign link_ready[stream_demux_pkg::STAGES] = tx_ready[stream_demux_pkg::EXTRACT_PORT];
    assign tx_beat[stream_demux_pkg::EXTRACT_PORT] = link_beat[stream_demux_pkg::STAGES];

endmodule

`default_nettype wire

// File: source/stream_demux_pkg.sv
`default_nettype none

package stream_demux_pkg;

    // beat payload.
    typedef logic [15:0] data_t;

    // destination field used for routing.
    typedef logic [3:0] dest_t;

    // user side-band, carried through untouched.
    typedef logic [1:0] user_t;

    // one beat of the stream, 23 bits in all.
    typedef struct packed {
        data_t data;
        dest_t dest;
        user_t user;
        logic  last;
    } stream_beat_t;

    // number of mapped tx ports.
    localparam int OUTPUTS = 6;

    // ports served by one demux stage.
    localparam int GROUP = 4;

    // stages in the chain, rounded up.
    localparam int STAGES = (OUTPUTS + GROUP - 1) / GROUP;

    // mapped ports plus the extract port.
    localparam int TX_PORTS = OUTPUTS + 1;

    // extract port takes beats that no stage claims.
    localparam int EXTRACT_PORT = OUTPUTS;

    // port i takes destination PORT_MAP[i]; entry 0 sits in the low bits.
    localparam dest_t [OUTPUTS-1:0] PORT_MAP = {4'd9, 4'd5, 4'd12, 4'd1, 4'd7, 4'd3};

    // first tx port index served by stage s.
    function automatic int stage_first(input int s);
        return s * GROUP;
    endfunction

    // number of ports served by stage s; the last stage may be short.
    function automatic int stage_width(input int s);
        int remainder;
        remainder = OUTPUTS - s * GROUP;
        return (GROUP < remainder) ? GROUP : remainder;
    endfunction

endpackage

`default_nettype wire

// File: source/stream_demux_stage.sv
`default_nettype none

module stream_demux_stage #(
    parameter int FIRST = 0,
    parameter int WIDTH = 4
) (
    input  logic                                     aclk,
    input  logic                                     areset_n,
    input  logic                                     prev_valid,
    output logic                                     prev_ready,
    input  stream_demux_pkg::stream_beat_t             prev_beat,
    output logic [WIDTH-1:0]                         tx_valid,
    input  logic [WIDTH-1:0]                         tx_ready,
    output stream_demux_pkg::stream_beat_t [WIDTH-1:0] tx_beat,
    output logic                                     next_valid,
    input  logic                                     next_ready,
    output stream_demux_pkg::stream_beat_t             next_beat
);

    // beat held at the slice output, waiting for its target.
    logic held_valid;
    logic held_ready;
    stream_demux_pkg::stream_beat_t held_beat;

    // one bit per port whose map entry equals the held dest.
    logic [WIDTH-1:0] hit;

    // no port in this group claims the beat.
    logic miss;

    // the one cycle of latency in this stage sits here.
    stream_slice slice (
        .aclk(aclk),
        .areset_n(areset_n),
        .in_valid(prev_valid),
        .in_ready(prev_ready),
        .in_beat(prev_beat),
        .out_valid(held_valid),
        .out_ready(held_ready),
        .out_beat(held_beat)
    );

    genvar i;

    generate
        for (i = 0; i < WIDTH; i++) begin : match
            // map entry for this group's port i.
            localparam stream_demux_pkg::dest_t ENTRY =
                stream_demux_pkg::PORT_MAP[FIRST + i];

            assign hit[i] = (held_beat.dest == ENTRY);

            // every port sees the same beat; only valid tells them apart.
            assign tx_beat[i] = held_beat;
        end
    endgenerate

    assign miss = !(|hit);

    // map entries are distinct, so at most one port is raised.
    assign tx_valid = hit & {WIDTH{held_valid}};

    // unclaimed beats move on down the chain.
    assign next_valid = held_valid && miss;
    assign next_beat = held_beat;

    // the slice only sees the ready of the target it picked.
    assign held_ready = miss ? next_ready : |(hit & tx_ready);

endmodule

`default_nettype wire

// File: source/stream_slice.sv
`default_nettype none

module stream_slice (
    input  logic                         aclk,
    input  logic                         areset_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  stream_demux_pkg::stream_beat_t in_beat,
    output logic                         out_valid,
    input  logic                         out_ready,
    output stream_demux_pkg::stream_beat_t out_beat
);

    // spare entry catches the beat accepted while the main one stalls.
    logic spare_valid;
    stream_demux_pkg::stream_beat_t spare_beat;

    logic accept;
    logic drain;
    logic load_main;
    logic out_valid_next;
    logic spare_valid_next;

    assign accept = in_valid && in_ready;
    assign drain = out_valid && out_ready;

    // main register takes a new beat when empty or leaving this cycle.
    assign load_main = !out_valid || drain;

    always_comb begin
        out_valid_next = out_valid;
        spare_valid_next = spare_valid;
        if (load_main) begin
            // spare goes first to keep order.
            out_valid_next = spare_valid || accept;
            spare_valid_next = 1'b0;
        end
        else if (accept) begin
            spare_valid_next = 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            out_valid <= 1'b0;
            spare_valid <= 1'b0;
            in_ready <= 1'b0;
        end
        else begin
            out_valid <= out_valid_next;
            spare_valid <= spare_valid_next;
            // ready is taken from the next fill state, so it never
            // depends on out_ready in the same cycle.
            in_ready <= !spare_valid_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (load_main) begin
            if (spare_valid) begin
                out_beat <= spare_beat;
            end
            else if (accept) begin
                out_beat <= in_beat;
            end
        end
        else if (accept) begin
            spare_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: test/demux_vectors.svh
`ifndef DEMUX_VECTORS_SVH
`define DEMUX_VECTORS_SVH

// columns: data, dest, user, last, expected tx port.
// ports 0 to 5 take dest 3, 7, 1, 12, 5, 9; anything else goes to port 6.
typedef struct packed {
    stream_demux_pkg::data_t data;
    stream_demux_pkg::dest_t dest;
    stream_demux_pkg::user_t user;
    logic                    last;
    logic [2:0]              port;
} vector_t;

localparam int NUM_VECTORS = 16;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{16'h1001, 4'd3,  2'd0, 1'b0, 3'd0},
    '{16'h2002, 4'd7,  2'd1, 1'b0, 3'd1},
    '{16'h3003, 4'd1,  2'd2, 1'b0, 3'd2},
    '{16'h4004, 4'd12, 2'd3, 1'b1, 3'd3},
    '{16'h5005, 4'd5,  2'd0, 1'b1, 3'd4},
    '{16'h6006, 4'd9,  2'd1, 1'b0, 3'd5},
    '{16'h7007, 4'd0,  2'd2, 1'b1, 3'd6},
    '{16'h8008, 4'd15, 2'd3, 1'b0, 3'd6},
    '{16'ha55a, 4'd3,  2'd1, 1'b1, 3'd0},
    '{16'h0f0f, 4'd9,  2'd2, 1'b1, 3'd5},
    '{16'hffff, 4'd2,  2'd0, 1'b1, 3'd6},
    '{16'h1234, 4'd12, 2'd1, 1'b0, 3'd3},
    '{16'hbeef, 4'd5,  2'd3, 1'b0, 3'd4},
    '{16'hcafe, 4'd7,  2'd0, 1'b1, 3'd1},
    '{16'h0000, 4'd1,  2'd1, 1'b1, 3'd2},
    '{16'hdead, 4'd4,  2'd2, 1'b0, 3'd6}
};

`endif

// File: test/stream_demux_tb.sv
`default_nettype none

module stream_demux_tb;

    // inputs move this long after each rising edge.
    localparam int DRIVE_DELAY = 5;

    // first pass with every tx ready high, second with random ready.
    localparam int PASSES = 2;

    // two slices of two entries each empty well within this many cycles.
    localparam int DRAIN_CYCLES = 16;

    `include "demux_vectors.svh"

    localparam int TIMEOUT_CYCLES = 16 + 8 * NUM_VECTORS * PASSES;

    // one beat waiting to leave on a port.
    typedef struct packed {
        stream_demux_pkg::stream_beat_t beat;
        int                             cycle;
        logic                           timed;
    } expect_t;

    logic aclk;
    logic areset_n;
    logic rx_valid;
    logic rx_ready;
    stream_demux_pkg::stream_beat_t rx_beat;
    logic [stream_demux_pkg::TX_PORTS-1:0] tx_valid;
    logic [stream_demux_pkg::TX_PORTS-1:0] tx_ready;
    stream_demux_pkg::stream_beat_t [stream_demux_pkg::TX_PORTS-1:0] tx_beat;

    // beats each port still owes, in input order.
    expect_t expect_q [stream_demux_pkg::TX_PORTS][$];

    logic random_ready;
    logic [31:0] random_word;
    integer seed = 99710;
    int cycles = 0;

    tb_clock clock_gen (
        .aclk(aclk),
        .areset_n(areset_n)
    );

    stream_demux DUT (
        .aclk(aclk),
        .areset_n(areset_n),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rx_beat(rx_beat),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_beat(tx_beat)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_value,
                               input logic [31:0] act_value);
        if (exp_value !== act_value) begin
            abort_run($sformatf("FAILED %s: expected %0h, actual %0h",
                                name, exp_value, act_value));
        end
    endtask

    // port whose map entry equals dest, else the extract port.
    function automatic int expected_port(input stream_demux_pkg::dest_t dest);
        int p;
        expected_port = stream_demux_pkg::EXTRACT_PORT;
        for (p = stream_demux_pkg::OUTPUTS - 1; p >= 0; p--) begin
            if (stream_demux_pkg::PORT_MAP[p] == dest) begin
                expected_port = p;
            end
        end
    endfunction

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int p = 0; p < stream_demux_pkg::TX_PORTS; p++) begin
            total += expect_q[p].size();
        end
        return total;
    endfunction

    task automatic check_idle(input string name);
        check_value({name, " rx_ready"}, 32'd0, 32'(rx_ready));
        check_value({name, " tx_valid"}, 32'd0, 32'(tx_valid));
    endtask

    // holds one table entry on rx until it transfers, then queues it.
    task automatic send_beat(input vector_t vec, input logic timed);
        stream_demux_pkg::stream_beat_t beat;
        expect_t entry;
        int port;
        beat.data = vec.data;
        beat.dest = vec.dest;
        beat.user = vec.user;
        beat.last = vec.last;
        port = expected_port(vec.dest);
        check_value("table port", 32'(vec.port), 32'(port));
        rx_valid = 1'b1;
        rx_beat = beat;
        // ready is stable by the falling edge, so the transfer edge is known.
        @(negedge aclk);
        // with every port open the chain takes one beat per cycle.
        if (timed) begin
            check_value("rx_ready at full rate", 32'd1, 32'(rx_ready));
        end
        while (!rx_ready) begin
            @(negedge aclk);
        end
        entry.beat = beat;
        entry.cycle = cycles;
        entry.timed = timed;
        expect_q[port].push_back(entry);
        @(posedge aclk);
        #DRIVE_DELAY;
    endtask

    // idle rx, open every port and let the queues empty.
    task automatic drain_ports();
        int waited;
        rx_valid = 1'b0;
        @(negedge aclk);
        random_ready = 1'b0;
        waited = 0;
        while (pending_beats() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge aclk);
            waited++;
        end
        // a few quiet cycles catch any stray beat.
        repeat (4) @(posedge aclk);
    endtask

    task automatic collect_port(input int p);
        expect_t entry;
        int latency;
        if (expect_q[p].size() == 0) begin
            abort_run($sformatf("port %0d delivered a beat that was never sent to it", p));
        end
        else begin
            entry = expect_q[p].pop_front();
            check_value($sformatf("port %0d beat", p), 32'(entry.beat), 32'(tx_beat[p]));
            if (entry.timed) begin
                // stage 0 ports after one cycle, stage 1 and extract after two.
                latency = (p <= 3) ? 1 : 2;
                check_value($sformatf("port %0d latency", p), latency, cycles - entry.cycle);
            end
        end
    endtask

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // tx ready changes with the other inputs, just after the edge.
    initial begin
        tx_ready = '1;
        forever begin
            @(posedge aclk);
            #DRIVE_DELAY;
            if (random_ready) begin
                random_word = $random(seed);
                tx_ready = random_word[stream_demux_pkg::TX_PORTS-1:0];
            end
            else begin
                tx_ready = '1;
            end
        end
    end

    // handshakes are sampled at the falling edge, where they are stable.
    always @(negedge aclk) begin
        for (int p = 0; p < stream_demux_pkg::TX_PORTS; p++) begin
            if (tx_valid[p] && tx_ready[p]) begin
                collect_port(p);
            end
        end
    end

    initial begin
        int pass;
        int i;
        rx_valid = 1'b0;
        rx_beat = '0;
        random_ready = 1'b0;
        @(negedge aclk);
        while (!areset_n) begin
            check_idle("reset");
            @(negedge aclk);
        end
        check_idle("after reset");
        for (pass = 0; pass < PASSES; pass++) begin
            @(negedge aclk);
            random_ready = (pass != 0);
            @(posedge aclk);
            #DRIVE_DELAY;
            for (i = 0; i < NUM_VECTORS; i++) begin
                send_beat(VECTORS[i], pass == 0);
            end
            drain_ports();
        end
        if (pending_beats() != 0) begin
            abort_run("beats were still queued at the end of the run");
        end
        else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic aclk,
    output logic areset_n
);

    // half of the 40 unit clock period.
    localparam int HALF_PERIOD = 20;

    // cycles spent in reset.
    localparam int RESET_CYCLES = 16;

    // reset leaves a little after an edge, like every other input.
    localparam int RELEASE_DELAY = 5;

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    initial begin
        areset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #RELEASE_DELAY;
        areset_n = 1'b1;
    end

endmodule

`default_nettype wire
